// File: Bender.yml
package:
  name: u2_ctrl

export_include_dirs:
  - include

sources:
  - files:
      - verilog/u2_ctrl_pkg.sv
      - verilog/settings_bus.sv
      - verilog/setting_reg.sv
      - verilog/ctrl_reg_bank.sv
      - verilog/status_readback.sv
      - verilog/u2_ctrl_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_u2_ctrl_core.sv

// File: include/u2_ctrl_config.svh
// Control plane configuration
// Bus widths, settings addresses and readback word indices
`ifndef U2_CTRL_CONFIG_SVH
`define U2_CTRL_CONFIG_SVH

////////////////////////////////////////////////////////////
// Bus widths
`define U2_AW       16
`define U2_DW       32
// Settings address comes from bus address bits 9 to 2
`define U2_SET_AW   8
// Readback word index comes from bus address bits 5 to 2
`define U2_RB_IW    4

////////////////////////////////////////////////////////////
// Settings addresses of the control registers
`define SR_CLK      0
`define SR_SER      1
`define SR_ADC      2
`define SR_LED      3
`define SR_PHY      4
`define SR_LED_SRC  8

////////////////////////////////////////////////////////////
// Readback page word indices
`define RB_STATUS       8
`define RB_MODE         9
`define RB_IRQ          13
`define RB_STATUS_ENC   14
`define RB_CYCLES       15

`endif

// File: list.f
+incdir+include
verilog/u2_ctrl_pkg.sv
verilog/settings_bus.sv
verilog/setting_reg.sv
verilog/ctrl_reg_bank.sv
verilog/status_readback.sv
verilog/u2_ctrl_core.sv
tb/tb_u2_ctrl_core.sv

// File: tb/tb_u2_ctrl_core.sv
// Testbench for the radio control plane
// Table-driven bus writes and reads with pin and readback checks
`timescale 1ns/1ps
`include "u2_ctrl_config.svh"

module tb_u2_ctrl_core;

   localparam int MAXR    = 48;
   localparam int TIMEOUT = 50;
   localparam int OP_NONE = 0;
   localparam int OP_WR   = 1;
   localparam int OP_RD   = 2;
   localparam int OP_CNT  = 3;

   logic        dsp_clk;
   logic        wb_rst;
   logic [15:0] wb_adr;
   logic [31:0] wb_dat_w;
   logic        wb_we;
   logic        wb_stb;
   logic        wb_ack;
   logic [31:0] wb_dat_r;
   logic        clk_status;
   logic        link_up;
   logic [31:0] status;
   logic [15:0] irq_src;
   logic        sim_mode;
   logic [3:0]  clk_div;
   // Pin bits from clock gen down to the LEDs
   wire  [21:0] pins;

   // Shadow copies of the setting registers
   logic [7:0]  sh_clk;
   logic [7:0]  sh_ser;
   logic [7:0]  sh_adc;
   logic [7:0]  sh_led;
   logic [7:0]  sh_src;
   logic        sh_phy;

   // Test table
   string       t_name [MAXR];
   int          t_op   [MAXR];
   logic [7:0]  t_addr [MAXR];
   logic [31:0] t_data [MAXR];
   logic        t_cs   [MAXR];
   logic        t_lu   [MAXR];
   logic [31:0] t_stat [MAXR];
   logic [15:0] t_irq  [MAXR];
   logic        t_sm   [MAXR];
   logic [3:0]  t_div  [MAXR];
   logic [31:0] t_exp  [MAXR];

   int          n_rows;
   int          errors;
   int          checks;
   int          timeouts;
   int          seed;
   int          row;

   u2_ctrl_core dut0 (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_we_i(wb_we), .wb_stb_i(wb_stb),
      .wb_ack_o(wb_ack), .wb_dat_o(wb_dat_r),
      .clk_status_i(clk_status), .serdes_link_up_i(link_up), .status_i(status),
      .irq_src_i(irq_src), .sim_mode_i(sim_mode), .clock_divider_i(clk_div),
      .clock_ready_o(pins[21]), .clk_en_o(pins[20:19]), .clk_sel_o(pins[18:17]),
      .ser_enable_o(pins[16]), .ser_prbsen_o(pins[15]),
      .ser_loopen_o(pins[14]), .ser_rx_en_o(pins[13]),
      .adc_oe_a_o(pins[12]), .adc_on_a_o(pins[11]),
      .adc_oe_b_o(pins[10]), .adc_on_b_o(pins[9]),
      .phy_resetn_o(pins[8]), .leds_o(pins[7:0]));

   always #20 dsp_clk = ~dsp_clk;

   ////////////////////////////////////////////////////////////
   // Reference model

   // Pin vector from the shadow registers and the hardware levels
   function automatic logic [31:0] expected_pins(input logic cs, input logic lu);
      logic [7:0] hw;
      logic [7:0] leds;
      hw = 8'h00;
      hw[1] = cs;
      hw[0] = lu;
      for (int b = 0; b < 8; b++) begin
         leds[b] = sh_src[b] ? hw[b] : sh_led[b];
      end
      return {10'b0, sh_clk[4], sh_clk[3:2], sh_clk[1:0], sh_ser[3], sh_ser[2],
              sh_ser[1], sh_ser[0], sh_adc[3:0], ~sh_phy, leds};
   endfunction

   // Highest set bit of the low half or all ones if none
   function automatic logic [31:0] highest_bit(input logic [31:0] st);
      logic [31:0] r;
      r = 32'hFFFF_FFFF;
      for (int b = 15; b >= 0; b--) begin
         if (st[b] && r == 32'hFFFF_FFFF) r = b;
      end
      return r;
   endfunction

   function automatic logic [31:0] expected_word(input logic [7:0] w, input logic [31:0] st,
                                                 input logic [15:0] irq, input logic sm,
                                                 input logic [3:0] div);
      if (w == `RB_STATUS) return st;
      else if (w == `RB_MODE) return {sm, 27'b0, div};
      else if (w == `RB_IRQ) return {16'b0, irq};
      else if (w == `RB_STATUS_ENC) return highest_bit(st);
      return 32'h0;
   endfunction

   task automatic add_row(input string name, input int op, input logic [7:0] addr,
                          input logic [31:0] data, input logic cs, input logic lu,
                          input logic [31:0] st, input logic [15:0] irq,
                          input logic sm, input logic [3:0] div);
      t_name[n_rows] = name;
      t_op[n_rows]   = op;
      t_addr[n_rows] = addr;
      t_data[n_rows] = data;
      t_cs[n_rows]   = cs;
      t_lu[n_rows]   = lu;
      t_stat[n_rows] = st;
      t_irq[n_rows]  = irq;
      t_sm[n_rows]   = sm;
      t_div[n_rows]  = div;
      if (op == OP_WR) begin
         case (addr)
            `SR_CLK:     sh_clk = data[7:0];
            `SR_SER:     sh_ser = data[7:0];
            `SR_ADC:     sh_adc = data[7:0];
            `SR_LED:     sh_led = data[7:0];
            `SR_PHY:     sh_phy = data[0];
            `SR_LED_SRC: sh_src = data[7:0];
            default:     ;
         endcase
      end
      if (op == OP_RD) t_exp[n_rows] = expected_word(addr, st, irq, sm, div);
      else if (op == OP_CNT) t_exp[n_rows] = 32'h1;
      else t_exp[n_rows] = expected_pins(cs, lu);
      n_rows++;
   endtask

   task automatic fill_table();
      logic [31:0] st;
      logic [15:0] irq;
      logic [31:0] rnd;
      add_row("reset_state", OP_NONE, 0, 0, 0, 0, 0, 0, 0, 0);
      add_row("clk_sel_en", OP_WR, `SR_CLK, 32'hFFFF_FF0B, 0, 0, 0, 0, 0, 0);
      add_row("clk_ready", OP_WR, `SR_CLK, 32'h0000_0014, 0, 0, 0, 0, 0, 0);
      add_row("ser_ctrl_a", OP_WR, `SR_SER, 32'hA5A5_A5F9, 0, 0, 0, 0, 0, 0);
      add_row("ser_ctrl_b", OP_WR, `SR_SER, 32'h0000_0006, 0, 0, 0, 0, 0, 0);
      add_row("adc_ctrl_a", OP_WR, `SR_ADC, 32'h0000_000C, 0, 0, 0, 0, 0, 0);
      add_row("adc_ctrl_b", OP_WR, `SR_ADC, 32'h1234_5673, 0, 0, 0, 0, 0, 0);
      add_row("phy_reset_on", OP_WR, `SR_PHY, 32'h0000_0001, 0, 0, 0, 0, 0, 0);
      add_row("phy_reset_off", OP_WR, `SR_PHY, 32'hFFFF_FFFE, 0, 0, 0, 0, 0, 0);
      add_row("led_sw", OP_WR, `SR_LED, 32'h0000_005A, 1, 0, 0, 0, 0, 0);
      add_row("led_src_low", OP_WR, `SR_LED_SRC, 32'h0000_0003, 0, 0, 0, 0, 0, 0);
      add_row("led_hw_01", OP_NONE, 0, 0, 0, 1, 0, 0, 0, 0);
      add_row("led_hw_11", OP_NONE, 0, 0, 1, 1, 0, 0, 0, 0);
      add_row("led_src_bit1", OP_WR, `SR_LED_SRC, 32'h0000_0002, 0, 1, 0, 0, 0, 0);
      add_row("led_hw_10", OP_NONE, 0, 0, 1, 0, 0, 0, 0, 0);
      add_row("led_src_high", OP_WR, `SR_LED_SRC, 32'h0000_00F1, 1, 1, 0, 0, 0, 0);
      add_row("led_src_off", OP_WR, `SR_LED_SRC, 32'h0000_0000, 1, 1, 0, 0, 0, 0);
      add_row("unused_addr_5", OP_WR, 5, 32'hFFFF_FFFF, 1, 1, 0, 0, 0, 0);
      add_row("unused_addr_44", OP_WR, 8'h44, 32'hFFFF_FFFF, 1, 1, 0, 0, 0, 0);
      // Random status shifted down so the top set bit moves around
      for (int k = 0; k < 3; k++) begin
         rnd = $random(seed);
         st  = $random(seed);
         st  = st >> rnd[4:0];
         irq = $random(seed);
         irq[15:13] = 3'b000;
         add_row($sformatf("rb_status_%0d", k), OP_RD, `RB_STATUS, 0, 0, 0, st, irq,
                 rnd[7], rnd[11:8]);
         add_row($sformatf("rb_mode_%0d", k), OP_RD, `RB_MODE, 0, 0, 0, st, irq,
                 rnd[7], rnd[11:8]);
         add_row($sformatf("rb_irq_%0d", k), OP_RD, `RB_IRQ, 0, 0, 0, st, irq,
                 rnd[7], rnd[11:8]);
         add_row($sformatf("rb_enc_%0d", k), OP_RD, `RB_STATUS_ENC, 0, 0, 0, st, irq,
                 rnd[7], rnd[11:8]);
      end
      add_row("rb_enc_zero", OP_RD, `RB_STATUS_ENC, 0, 0, 0, 0, 0, 0, 0);
      add_row("rb_enc_upper", OP_RD, `RB_STATUS_ENC, 0, 0, 0, 32'hFFFF_0000, 0, 0, 0);
      add_row("rb_unused_3", OP_RD, 3, 0, 0, 0, 32'hDEAD_BEEF, 16'h1FFF, 1, 4'hF);
      add_row("cycle_count", OP_CNT, `RB_CYCLES, 0, 0, 0, 0, 0, 0, 0);
   endtask

   ////////////////////////////////////////////////////////////
   // Bus access and checks

   // One bus cycle held until the acknowledge or the timeout
   task automatic bus_cycle(input logic we, input logic [15:0] adr, input logic [31:0] dat,
                            output logic [31:0] rdat);
      int n;
      @(posedge dsp_clk);
      wb_adr   <= adr;
      wb_dat_w <= dat;
      wb_we    <= we;
      wb_stb   <= 1'b1;
      n = 0;
      do begin
         @(posedge dsp_clk);
         n++;
      end while (!wb_ack && n < TIMEOUT);
      rdat = wb_dat_r;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
      if (!wb_ack) begin
         timeouts++;
         $display("Timeout: bus access to address 0x%04h was never acknowledged", adr);
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, exp, act);
      end
   endtask

   task automatic apply_row(input int r);
      logic [31:0] rd_a;
      logic [31:0] rd_b;
      @(posedge dsp_clk);
      clk_status <= t_cs[r];
      link_up    <= t_lu[r];
      status     <= t_stat[r];
      irq_src    <= t_irq[r];
      sim_mode   <= t_sm[r];
      clk_div    <= t_div[r];
      case (t_op[r])
         OP_WR: begin
            bus_cycle(1'b1, {6'b0, t_addr[r], 2'b00}, t_data[r], rd_a);
            repeat (2) @(posedge dsp_clk);
            if (timeouts == 0) check_value(t_name[r], t_exp[r], {10'b0, pins});
         end
         OP_RD: begin
            bus_cycle(1'b0, {6'b0, t_addr[r], 2'b00}, 32'h0, rd_a);
            if (timeouts == 0) check_value(t_name[r], t_exp[r], rd_a);
         end
         OP_CNT: begin
            bus_cycle(1'b0, {6'b0, t_addr[r], 2'b00}, 32'h0, rd_a);
            bus_cycle(1'b0, {6'b0, t_addr[r], 2'b00}, 32'h0, rd_b);
            // Second value must be strictly larger
            if (timeouts == 0) check_value(t_name[r], t_exp[r], {31'b0, rd_b > rd_a});
         end
         default: begin
            repeat (2) @(posedge dsp_clk);
            check_value(t_name[r], t_exp[r], {10'b0, pins});
         end
      endcase
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   initial begin
      dsp_clk    = 1'b0;
      wb_rst     = 1'b1;
      wb_adr     = '0;
      wb_dat_w   = '0;
      wb_we      = 1'b0;
      wb_stb     = 1'b0;
      clk_status = 1'b0;
      link_up    = 1'b0;
      status     = '0;
      irq_src    = '0;
      sim_mode   = 1'b0;
      clk_div    = '0;
      sh_clk     = '0;
      sh_ser     = '0;
      sh_adc     = '0;
      sh_led     = '0;
      sh_src     = '0;
      sh_phy     = 1'b0;
      seed       = 92;
      n_rows     = 0;
      errors     = 0;
      checks     = 0;
      timeouts   = 0;
      fill_table();
      repeat (16) @(posedge dsp_clk);
      wb_rst <= 1'b0;
      for (row = 0; row < n_rows && timeouts == 0; row++) begin
         apply_row(row);
      end
      $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// File: verilog/ctrl_reg_bank.sv
// Control register bank of the radio core
// Drives clock gen, SERDES, ADC, PHY reset and LED pins
`timescale 1ns/1ps
`include "u2_ctrl_config.svh"

module ctrl_reg_bank (
   input  logic                     dsp_clk,
   input  logic                     wb_rst,
   input  logic                     set_stb_i,
   input  u2_ctrl_pkg::set_addr_t   set_addr_i,
   input  u2_ctrl_pkg::wb_dat_t     set_data_i,
   input  logic                     clk_status_i,
   input  logic                     serdes_link_up_i,
   output logic                     clock_ready_o,
   output logic [1:0]               clk_en_o,
   output logic [1:0]               clk_sel_o,
   output logic                     ser_enable_o,
   output logic                     ser_prbsen_o,
   output logic                     ser_loopen_o,
   output logic                     ser_rx_en_o,
   output logic                     adc_oe_a_o,
   output logic                     adc_on_a_o,
   output logic                     adc_oe_b_o,
   output logic                     adc_on_b_o,
   output logic                     phy_resetn_o,
   output u2_ctrl_pkg::ctrl_byte_t  leds_o
);

   import u2_ctrl_pkg::*;

   ctrl_byte_t clock_outs;
   ctrl_byte_t serdes_outs;
   ctrl_byte_t adc_outs;
   ctrl_byte_t led_sw;
   ctrl_byte_t led_src;
   ctrl_byte_t led_hw;
   logic       phy_reset;

   ////////////////////////////////////////////////////////////
   // Setting registers
   setting_reg #(.my_addr(`SR_CLK), .payload_t(ctrl_byte_t)) sr_clk (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i), .out_o(clock_outs));

   setting_reg #(.my_addr(`SR_SER), .payload_t(ctrl_byte_t)) sr_ser (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i), .out_o(serdes_outs));

   setting_reg #(.my_addr(`SR_ADC), .payload_t(ctrl_byte_t)) sr_adc (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i), .out_o(adc_outs));

   // PHY reset is a single flag
   setting_reg #(.my_addr(`SR_PHY), .payload_t(logic)) sr_phy (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i), .out_o(phy_reset));

   setting_reg #(.my_addr(`SR_LED), .payload_t(ctrl_byte_t)) sr_led (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i), .out_o(led_sw));

   setting_reg #(.my_addr(`SR_LED_SRC), .payload_t(ctrl_byte_t)) sr_led_src (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i), .out_o(led_src));

   ////////////////////////////////////////////////////////////
   // Pin mapping
   assign {clock_ready_o, clk_en_o, clk_sel_o} = clock_outs[4:0];
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = serdes_outs[3:0];
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_outs[3:0];

   // Register holds the reset request, pin is active low
   assign phy_resetn_o = ~phy_reset;

   ////////////////////////////////////////////////////////////
   // LED merge
   // A set source bit hands that LED to hardware status
   assign led_hw = {6'b0, clk_status_i, serdes_link_up_i};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

// File: verilog/setting_reg.sv
// Single addressed setting register
// Loads the low bits of the settings data on a matching strobe
`timescale 1ns/1ps

module setting_reg #(
   parameter u2_ctrl_pkg::set_addr_t my_addr = '0,
   parameter type payload_t = logic [7:0]
) (
   input  logic                   dsp_clk,
   input  logic                   wb_rst,
   input  logic                   set_stb_i,
   input  u2_ctrl_pkg::set_addr_t set_addr_i,
   input  u2_ctrl_pkg::wb_dat_t   set_data_i,
   output payload_t               out_o
);

   // Payload width, 8 for control bytes and 1 for single flags
   localparam int PW = $bits(payload_t);

   logic hit;

   assign hit = set_stb_i && (set_addr_i == my_addr);

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         out_o <= '0;
      end else if (hit) begin
         out_o <= set_data_i[PW-1:0];
      end
   end

endmodule

// File: verilog/settings_bus.sv
// Settings bus write slave
// Turns single bus writes into a one-cycle settings strobe
`timescale 1ns/1ps
`include "u2_ctrl_config.svh"

module settings_bus (
   input  logic                   dsp_clk,
   input  logic                   wb_rst,
   input  u2_ctrl_pkg::wb_adr_t   wb_adr_i,
   input  u2_ctrl_pkg::wb_dat_t   wb_dat_i,
   input  logic                   wb_stb_i,
   input  logic                   wb_we_i,
   output logic                   wb_ack_o,
   output logic                   set_stb_o,
   output u2_ctrl_pkg::set_addr_t set_addr_o,
   output u2_ctrl_pkg::wb_dat_t   set_data_o
);

   logic wr_req;
   logic stb_q;

   // No accept in the cycle right after an acknowledge,
   // the master still holds the old write there
   assign wr_req = wb_stb_i & wb_we_i & ~stb_q;

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         stb_q <= 1'b0;
      end else begin
         stb_q <= wr_req;
      end
   end

   // Word address and data of the accepted write
   always_ff @(posedge dsp_clk) begin
      if (wr_req) begin
         set_addr_o <= wb_adr_i[`U2_SET_AW+1:2];
         set_data_o <= wb_dat_i;
      end
   end

   // Acknowledge and strobe share one cycle
   assign wb_ack_o  = stb_q;
   assign set_stb_o = stb_q;

endmodule

// File: verilog/status_readback.sv
// Status readback slave
// Returns the status page, cycle counter and priority encoding
`timescale 1ns/1ps
`include "u2_ctrl_config.svh"

module status_readback (
   input  logic                  dsp_clk,
   input  logic                  wb_rst,
   input  u2_ctrl_pkg::wb_adr_t  wb_adr_i,
   input  logic                  wb_stb_i,
   input  logic                  wb_we_i,
   output logic                  wb_ack_o,
   output u2_ctrl_pkg::wb_dat_t  wb_dat_o,
   input  u2_ctrl_pkg::wb_dat_t  status_i,
   input  u2_ctrl_pkg::irq_src_t irq_src_i,
   input  logic                  sim_mode_i,
   input  logic [3:0]            clock_divider_i
);

   import u2_ctrl_pkg::*;

   logic                 rd_req;
   logic                 ack_q;
   logic [`U2_RB_IW-1:0] word_idx;
   wb_dat_t              cycle_count;
   wb_dat_t              status_enc;
   wb_dat_t              rd_word;

   // Index of the highest set bit, all ones when none is set
   function automatic wb_dat_t prio_enc(input logic [15:0] bits);
      wb_dat_t idx;
      idx = '1;
      for (int i = 0; i < 16; i++) begin
         if (bits[i]) begin
            idx = wb_dat_t'(i);
         end
      end
      return idx;
   endfunction

   ////////////////////////////////////////////////////////////
   // Free-running cycle counter
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         cycle_count <= '0;
      end else begin
         cycle_count <= cycle_count + 1'b1;
      end
   end

   assign status_enc = prio_enc(status_i[15:0]);

   ////////////////////////////////////////////////////////////
   // Word select
   assign word_idx = wb_adr_i[`U2_RB_IW+1:2];

   always_comb begin
      case (word_idx)
         `RB_STATUS:     rd_word = status_i;
         `RB_MODE:       rd_word = {sim_mode_i, 27'b0, clock_divider_i};
         `RB_IRQ:        rd_word = {16'b0, irq_src_i};
         `RB_STATUS_ENC: rd_word = status_enc;
         `RB_CYCLES:     rd_word = cycle_count;
         // Buffer pool words and spare slots
         default:        rd_word = '0;
      endcase
   end

   // One acknowledge per read, skip the cycle after it
   assign rd_req = wb_stb_i & ~wb_we_i & ~ack_q;

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= rd_req;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (rd_req) begin
         wb_dat_o <= rd_word;
      end
   end

   assign wb_ack_o = ack_q;

endmodule

// File: verilog/u2_ctrl_core.sv
// Control plane top of the radio core
// Bus write path to the setting registers and status readback
`timescale 1ns/1ps

module u2_ctrl_core (
   input  logic                    dsp_clk,
   input  logic                    wb_rst,
   // Bus
   input  u2_ctrl_pkg::wb_adr_t    wb_adr_i,
   input  u2_ctrl_pkg::wb_dat_t    wb_dat_i,
   input  logic                    wb_we_i,
   input  logic                    wb_stb_i,
   output logic                    wb_ack_o,
   output u2_ctrl_pkg::wb_dat_t    wb_dat_o,
   // Hardware status
   input  logic                    clk_status_i,
   input  logic                    serdes_link_up_i,
   input  u2_ctrl_pkg::wb_dat_t    status_i,
   input  u2_ctrl_pkg::irq_src_t   irq_src_i,
   input  logic                    sim_mode_i,
   input  logic [3:0]              clock_divider_i,
   // Clock gen
   output logic                    clock_ready_o,
   output logic [1:0]              clk_en_o,
   output logic [1:0]              clk_sel_o,
   // SERDES
   output logic                    ser_enable_o,
   output logic                    ser_prbsen_o,
   output logic                    ser_loopen_o,
   output logic                    ser_rx_en_o,
   // ADC
   output logic                    adc_oe_a_o,
   output logic                    adc_on_a_o,
   output logic                    adc_oe_b_o,
   output logic                    adc_on_b_o,
   // Misc
   output logic                    phy_resetn_o,
   output u2_ctrl_pkg::ctrl_byte_t leds_o
);

   import u2_ctrl_pkg::*;

   logic      set_stb;
   set_addr_t set_addr;
   wb_dat_t   set_data;
   logic      wr_ack;
   logic      rd_ack;

   ////////////////////////////////////////////////////////////
   // Write path, bus stage then register stage
   settings_bus settings_bus0 (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_stb_i(wb_stb_i),
      .wb_we_i(wb_we_i), .wb_ack_o(wr_ack),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   ctrl_reg_bank ctrl_reg_bank0 (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .clk_status_i(clk_status_i), .serdes_link_up_i(serdes_link_up_i),
      .clock_ready_o(clock_ready_o), .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o),
      .phy_resetn_o(phy_resetn_o), .leds_o(leds_o));

   ////////////////////////////////////////////////////////////
   // Read path
   status_readback status_readback0 (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .wb_adr_i(wb_adr_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
      .wb_ack_o(rd_ack), .wb_dat_o(wb_dat_o),
      .status_i(status_i), .irq_src_i(irq_src_i),
      .sim_mode_i(sim_mode_i), .clock_divider_i(clock_divider_i));

   // Slaves split on write enable, so at most one acknowledges
   assign wb_ack_o = wr_ack | rd_ack;

endmodule

// File: verilog/u2_ctrl_pkg.sv
// Shared types of the radio control plane
// Bus words, settings addresses, control bytes and the irq vector
`include "u2_ctrl_config.svh"

package u2_ctrl_pkg;

   // Bus address and data words
   typedef logic [`U2_AW-1:0]     wb_adr_t;
   typedef logic [`U2_DW-1:0]     wb_dat_t;

   // Settings bus address
   typedef logic [`U2_SET_AW-1:0] set_addr_t;

   // Payload of the control and LED registers
   typedef logic [7:0]            ctrl_byte_t;

   // Interrupt sources, bit 0 (buffer) is the last field
   typedef struct packed {
      logic [2:0] reserved;
      logic       periodic;
      logic       clk_status;
      logic       serdes_link_up;
      logic       uart_tx;
      logic       uart_rx;
      logic       pps;
      logic       overrun;
      logic       underrun;
      logic       phy_int_n;
      logic       i2c;
      logic       spi;
      logic       onetime;
      logic       buffer;
   } irq_src_t;

endpackage
